/* vlog.f */
+incdir+include
verilog/div_data_pkg.sv
verilog/div_ctrl_pkg.sv
verilog/div_remainder_unit.sv
verilog/div_quotient_unit.sv
verilog/div_control.sv
verilog/signed_divider.sv
tb/tb_signed_divider.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module tb_signed_divider -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_signed_divider > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

/* include/div_ref_model.svh */
// expected divider results and a small LCG, included into the testbench module
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// starting state of the random operand generator
localparam int unsigned lcg_seed = 97;

// next LCG state, the usual 32-bit multiplier and increment
function automatic logic [31:0] lcg_next(input logic [31:0] lcg_state);
    return lcg_state * 32'd1664525 + 32'd1013904223;
endfunction

// truncating signed division in 33 bits, so most negative / -1 still fits
function automatic div_data_pkg::div_result_t div_ref_model(
    input div_data_pkg::word_t dividend,
    input div_data_pkg::word_t divisor
);
    div_data_pkg::div_result_t             expected;
    logic signed [div_data_pkg::long_width-1:0] numerator;
    logic signed [div_data_pkg::long_width-1:0] denominator;
    logic signed [div_data_pkg::long_width-1:0] quotient_long;
    logic signed [div_data_pkg::long_width-1:0] remainder_long;
    numerator   = {dividend[div_data_pkg::word_width-1], dividend};
    denominator = {divisor[div_data_pkg::word_width-1], divisor};
    if (denominator == 0) begin
        // -1 for zero or positive dividends, +1 for negative ones
        if (numerator[div_data_pkg::long_width-1]) begin
            expected.quotient = div_data_pkg::word_t'(1);
        end else begin
            expected.quotient = {div_data_pkg::word_width{1'b1}};
        end
        expected.remainder      = dividend;
        expected.divide_by_zero = 1'b1;
    end else begin
        // operators truncate toward zero, remainder keeps the dividend sign
        quotient_long           = numerator / denominator;
        remainder_long          = numerator % denominator;
        expected.quotient       = quotient_long[div_data_pkg::word_width-1:0];
        expected.remainder      = remainder_long[div_data_pkg::word_width-1:0];
        expected.divide_by_zero = 1'b0;
    end
    return expected;
endfunction

`endif

/* tb/tb_signed_divider.sv */
// testbench for signed_divider, drives directed and random operands and checks every result
`timescale 1ns/1ps

module tb_signed_divider;

    // accept waits can stretch by a whole division plus back-pressure
    localparam int handshake_timeout = 1000;
    localparam int drain_timeout     = 1000;
    localparam int random_count      = 300;

    logic                       clock = 1'b0;
    logic                       arst_n;
    logic                       in_valid;
    logic                       in_ready;
    div_data_pkg::div_request_t request;
    logic                       out_valid;
    logic                       out_ready;
    div_data_pkg::div_result_t  result;

    // requests accepted by the DUT and not yet read back
    div_data_pkg::div_request_t expected_queue[$];

    int          mismatch_count    = 0;
    int          other_error_count = 0;
    int          timeout_count     = 0;
    int          sent_count        = 0;
    int          checked_count     = 0;
    bit          timed_out         = 1'b0;
    logic [31:0] operand_state;

    // checker state
    int                        cycle_count       = 0;
    int                        accept_cycle      = 0;
    bit                        busy              = 1'b0;
    bit                        prev_out_valid    = 1'b0;
    bit                        expect_ready_next = 1'b0;
    div_data_pkg::div_result_t held_result;

    `include "div_ref_model.svh"

    signed_divider dut (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .request   (request),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    // 40 ns period
    always #20 clock = ~clock;

    // present one operand pair and hold it until the DUT takes it
    task automatic send_request(input div_data_pkg::word_t dividend,
                                input div_data_pkg::word_t divisor);
        int   wait_cycles;
        logic accepted;
        wait_cycles = 0;
        accepted    = 1'b0;
        if (!timed_out) begin
            request  = '{dividend: dividend, divisor: divisor};
            in_valid = 1'b1;
            while (!accepted && wait_cycles < handshake_timeout) begin
                @(posedge clock);
                accepted    = in_ready;
                wait_cycles = wait_cycles + 1;
            end
            @(negedge clock);
            in_valid = 1'b0;
            if (accepted) begin
                sent_count = sent_count + 1;
            end else begin
                $display("timeout at %0t: request %h / %h was never accepted",
                         $time, dividend, divisor);
                timeout_count = timeout_count + 1;
                timed_out     = 1'b1;
            end
        end
    endtask

    // directed cases take plain integers
    task automatic send_int(input int dividend, input int divisor);
        send_request(div_data_pkg::word_t'(dividend), div_data_pkg::word_t'(divisor));
    endtask

    task automatic run_random(input int count);
        div_data_pkg::word_t dividend;
        div_data_pkg::word_t divisor;
        for (int n = 0; n < count; n++) begin
            operand_state = lcg_next(operand_state);
            dividend      = operand_state;
            operand_state = lcg_next(operand_state);
            divisor       = operand_state;
            operand_state = lcg_next(operand_state);
            // one in eight divisors is zero, three in eight are shortened
            // so that the quotient gets more bits
            if (operand_state[31:29] == 3'd0) begin
                divisor = '0;
            end else if (operand_state[31:29] < 3'd4) begin
                divisor = div_data_pkg::word_t'($signed(divisor) >>> operand_state[28:24]);
            end
            send_request(dividend, divisor);
        end
    endtask

    task automatic wait_for_drain();
        int wait_cycles;
        wait_cycles = 0;
        while (expected_queue.size() != 0 && wait_cycles < drain_timeout) begin
            @(negedge clock);
            wait_cycles = wait_cycles + 1;
        end
        if (expected_queue.size() != 0) begin
            $display("timeout at %0t: %0d results never came out",
                     $time, expected_queue.size());
            timeout_count = timeout_count + 1;
        end
    endtask

    // one if per field, against the reference model
    task automatic check_result(input div_data_pkg::div_request_t req,
                                input div_data_pkg::div_result_t got);
        div_data_pkg::div_result_t expected;
        expected = div_ref_model(req.dividend, req.divisor);
        if (got.quotient != expected.quotient) begin
            $display("mismatch at %0t: quotient of %h / %h is %h, expected %h",
                     $time, req.dividend, req.divisor, got.quotient, expected.quotient);
            mismatch_count = mismatch_count + 1;
        end
        if (got.remainder != expected.remainder) begin
            $display("mismatch at %0t: remainder of %h / %h is %h, expected %h",
                     $time, req.dividend, req.divisor, got.remainder, expected.remainder);
            mismatch_count = mismatch_count + 1;
        end
        if (got.divide_by_zero != expected.divide_by_zero) begin
            $display("mismatch at %0t: divide_by_zero of %h / %h is %b, expected %b",
                     $time, req.dividend, req.divisor, got.divide_by_zero,
                     expected.divide_by_zero);
            mismatch_count = mismatch_count + 1;
        end
        checked_count = checked_count + 1;
    endtask

    // sink withholds out_ready about one cycle in four
    initial begin
        logic [31:0] ready_state;
        out_ready   = 1'b0;
        ready_state = lcg_next(lcg_seed);
        forever begin
            @(negedge clock);
            ready_state = lcg_next(ready_state);
            out_ready   = (ready_state[31:30] != 2'b00);
        end
    end

    // samples pre-edge values, everything here was settled half a period earlier
    always @(posedge clock) begin
        if (arst_n) begin
            cycle_count = cycle_count + 1;
            if (expect_ready_next && !in_ready) begin
                $display("mismatch at %0t: in_ready low one cycle after output transfer", $time);
                mismatch_count = mismatch_count + 1;
            end
            expect_ready_next = 1'b0;
            if (busy && in_ready) begin
                $display("mismatch at %0t: in_ready high while a division is in flight", $time);
                mismatch_count = mismatch_count + 1;
            end
            // out_valid rose on the previous edge
            if (out_valid && !prev_out_valid && (cycle_count - 1 - accept_cycle != 33)) begin
                $display("mismatch at %0t: out_valid rose %0d edges after accept, expected 33",
                         $time, cycle_count - 1 - accept_cycle);
                mismatch_count = mismatch_count + 1;
            end
            if (out_valid && prev_out_valid && (result != held_result)) begin
                $display("mismatch at %0t: result changed from %h to %h under back-pressure",
                         $time, held_result, result);
                mismatch_count = mismatch_count + 1;
            end
            if (in_valid && in_ready) begin
                expected_queue.push_back(request);
                accept_cycle = cycle_count;
                busy         = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (expected_queue.size() == 0) begin
                    $display("output transfer at %0t with no request outstanding", $time);
                    other_error_count = other_error_count + 1;
                end else begin
                    check_result(expected_queue.pop_front(), result);
                end
                busy              = 1'b0;
                expect_ready_next = 1'b1;
            end
            held_result    = result;
            prev_out_valid = out_valid;
        end
    end

    initial begin
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        request       = '0;
        operand_state = lcg_seed;
        repeat (16) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        if (!in_ready || out_valid) begin
            $display("mismatch at %0t: after reset in_ready %b out_valid %b, expected 1 and 0",
                     $time, in_ready, out_valid);
            mismatch_count = mismatch_count + 1;
        end

        // every sign combination
        send_int(22, 7);
        send_int(-22, 7);
        send_int(22, -7);
        send_int(-22, -7);
        send_int(7, 22);
        send_int(-7, -22);
        send_int(-7, 22);
        send_int(7, -22);

        // zero divisors
        send_int(0, 0);
        send_int(22, 0);
        send_int(-22, 0);

        // most negative word, min / -1 wraps
        send_request(32'h8000_0000, 32'h0000_0001);
        send_request(32'h8000_0000, 32'hffff_ffff);
        send_request(32'h8000_0000, 32'h8000_0000);
        send_request(32'h7fff_ffff, 32'h8000_0000);

        run_random(random_count);
        wait_for_drain();

        if (!timed_out && (checked_count != sent_count)) begin
            $display("%0d requests were accepted but %0d results were checked",
                     sent_count, checked_count);
            other_error_count = other_error_count + 1;
        end

        $display("error counts: %0d mismatches, %0d other errors, %0d timeouts",
                 mismatch_count, other_error_count, timeout_count);
        if (mismatch_count == 0 && other_error_count == 0 && timeout_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog/signed_divider.sv */
// top level of the iterative signed divider, one request in flight at a time
`timescale 1ns/1ps

module signed_divider (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  div_data_pkg::div_request_t request,
    output logic                       out_valid,
    input  logic                       out_ready,
    output div_data_pkg::div_result_t  result
);

    div_ctrl_pkg::div_ctrl_t ctrl;
    div_data_pkg::word_t     quotient;
    div_data_pkg::word_t     remainder;
    logic                    divide_by_zero;
    logic                    step_valid;
    logic                    quotient_subtract;

    // handshakes, state and step count
    div_control u_control (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .ctrl      (ctrl)
    );

    // remainder side also decides whether each step counts
    div_remainder_unit u_remainder (
        .clock             (clock),
        .arst_n            (arst_n),
        .ctrl              (ctrl),
        .dividend          (request.dividend),
        .divisor           (request.divisor),
        .remainder         (remainder),
        .divide_by_zero    (divide_by_zero),
        .step_valid        (step_valid),
        .quotient_subtract (quotient_subtract)
    );

    div_quotient_unit u_quotient (
        .clock             (clock),
        .arst_n            (arst_n),
        .ctrl              (ctrl),
        .step_valid        (step_valid),
        .quotient_subtract (quotient_subtract),
        .quotient          (quotient)
    );

    assign result = '{quotient: quotient, remainder: remainder, divide_by_zero: divide_by_zero};

endmodule

/* verilog/div_control.sv */
// FSM and step counter of the divider, drives both handshakes and the datapath controls
`timescale 1ns/1ps

module div_control (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic                    out_valid,
    input  logic                    out_ready,
    output div_ctrl_pkg::div_ctrl_t ctrl
);

    div_ctrl_pkg::div_state_e state;
    div_ctrl_pkg::step_t      step;
    logic                     load_inputs;
    logic                     read_outputs;
    logic                     calculating;
    logic                     last_step;

    // ready and valid come from state alone
    // which keeps the two handshakes free of combinational loops
    assign in_ready  = (state == div_ctrl_pkg::state_load);
    assign out_valid = (state == div_ctrl_pkg::state_done);

    // events derived from state and handshakes
    assign load_inputs  = in_ready && in_valid;
    assign read_outputs = out_valid && out_ready;
    assign calculating  = (state == div_ctrl_pkg::state_calc);
    assign last_step    = calculating && (step == '0);

    assign ctrl = '{load: load_inputs, calculating: calculating};

    // load -> calc -> done -> load
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= div_ctrl_pkg::state_load;
        end else begin
            case (state)
                div_ctrl_pkg::state_load: begin
                    if (load_inputs) begin
                        state <= div_ctrl_pkg::state_calc;
                    end
                end
                div_ctrl_pkg::state_calc: begin
                    if (last_step) begin
                        state <= div_ctrl_pkg::state_done;
                    end
                end
                div_ctrl_pkg::state_done: begin
                    // hold result until the sink takes it
                    if (read_outputs) begin
                        state <= div_ctrl_pkg::state_load;
                    end
                end
                default: begin
                    state <= div_ctrl_pkg::state_load;
                end
            endcase
        end
    end

    // counts 32 down to 0 while calculating, stops at 0
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            step <= '0;
        end else if (load_inputs) begin
            step <= div_ctrl_pkg::steps_initial;
        end else if (calculating && (step != '0)) begin
            step <= step - div_ctrl_pkg::step_t'(1);
        end
    end

    a_ready_valid_exclusive: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(in_ready && out_valid)
    );

    // back-pressure keeps the result in place
    a_done_held: assert property (
        @(posedge clock) disable iff (!arst_n)
        (out_valid && !out_ready) |=> out_valid
    );

endmodule

/* verilog/div_quotient_unit.sv */
// quotient side of the divider, accumulates a one-hot weight on every valid step
`timescale 1ns/1ps

module div_quotient_unit (
    input  logic                    clock,
    input  logic                    arst_n,
    input  div_ctrl_pkg::div_ctrl_t ctrl,
    input  logic                    step_valid,
    input  logic                    quotient_subtract,
    output div_data_pkg::word_t     quotient
);

    div_data_pkg::long_t increment;
    div_data_pkg::long_t quotient_long;

    // weight of the current step
    // starts at the top bit and halves each calc cycle, in step
    // with the divisor shifting on the remainder side
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            increment <= '0;
        end else if (ctrl.load) begin
            increment <= {1'b1, {div_data_pkg::word_width{1'b0}}};
        end else if (ctrl.calculating) begin
            increment <= increment >> 1;
        end
    end

    // cleared on load
    // a valid step adds the weight, or takes it away for opposite signs
    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            quotient_long <= '0;
        end else if (step_valid) begin
            if (quotient_subtract) begin
                quotient_long <= quotient_long - increment;
            end else begin
                quotient_long <= quotient_long + increment;
            end
        end
    end

    // most negative divided by -1 wraps here, as intended
    assign quotient = quotient_long[div_data_pkg::word_width-1:0];

    // weight never holds more than one bit
    a_increment_onehot: assert property (
        @(posedge clock) disable iff (!arst_n)
        $onehot0(increment)
    );

endmodule

/* verilog/div_remainder_unit.sv */
// remainder side of the divider that shifts the divisor and takes it off the dividend
`timescale 1ns/1ps

module div_remainder_unit (
    input  logic                    clock,
    input  logic                    arst_n,
    input  div_ctrl_pkg::div_ctrl_t ctrl,
    input  div_data_pkg::word_t     dividend,
    input  div_data_pkg::word_t     divisor,
    output div_data_pkg::word_t     remainder,
    output logic                    divide_by_zero,
    output logic                    step_valid,
    output logic                    quotient_subtract
);

    div_data_pkg::long_t dividend_long;
    div_data_pkg::long_t divisor_long;
    div_data_pkg::long_t divisor_shift;
    div_data_pkg::long_t increment;
    div_data_pkg::long_t remainder_long;
    div_data_pkg::long_t remainder_next;
    logic                dividend_sign;
    logic                divisor_sign;
    logic                divisor_all_sign;
    logic                increment_usable;
    logic                overshoot;

    // sign extend both operands by one bit
    assign dividend_long = {dividend[div_data_pkg::word_width-1], dividend};
    assign divisor_long  = {divisor[div_data_pkg::word_width-1], divisor};

    // operand signs held for the whole division
    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            dividend_sign <= dividend_long[div_data_pkg::long_width-1];
            divisor_sign  <= divisor_long[div_data_pkg::long_width-1];
        end
    end

    // zero divisor flag travels with the result
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            divide_by_zero <= 1'b0;
        end else if (ctrl.load) begin
            divide_by_zero <= (divisor == '0);
        end
    end

    // quotient counts down when the signs differ
    // and the remainder then grows toward zero by adding
    assign quotient_subtract = (dividend_sign != divisor_sign);

    // divisor is split in two registers
    // the low bit goes straight into the top of the increment on load
    // the rest shifts right arithmetically one bit per step
    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            divisor_shift <= {divisor_long[div_data_pkg::long_width-1],
                              divisor_long[div_data_pkg::long_width-1:1]};
            increment     <= {divisor_long[0], {div_data_pkg::word_width{1'b0}}};
        end else if (ctrl.calculating) begin
            divisor_shift <= {divisor_shift[div_data_pkg::long_width-1],
                              divisor_shift[div_data_pkg::long_width-1:1]};
            increment     <= {divisor_shift[0],
                              increment[div_data_pkg::long_width-1:1]};
        end
    end

    // increment is only a real multiple of the divisor once
    // nothing but sign bits are left behind in the shift register
    assign divisor_all_sign = divisor_sign ? (divisor_shift == '1) : (divisor_shift == '0);

    // and the increment has picked up the divisor sign
    assign increment_usable = (increment[div_data_pkg::long_width-1] == divisor_sign)
                              && divisor_all_sign;

    // candidate remainder for this step
    assign remainder_next = quotient_subtract ? (remainder_long + increment)
                                              : (remainder_long - increment);

    // step went past zero if the sign flipped away from the dividend
    // landing exactly on zero is fine
    assign overshoot = (remainder_next[div_data_pkg::long_width-1] != dividend_sign)
                       && (remainder_next != '0);

    assign step_valid = ctrl.calculating && increment_usable && !overshoot;

    // dividend seeds the remainder
    // each valid step takes out one multiple
    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            remainder_long <= dividend_long;
        end else if (step_valid) begin
            remainder_long <= remainder_next;
        end
    end

    // low word is enough since the remainder magnitude never exceeds the dividend
    assign remainder = remainder_long[div_data_pkg::word_width-1:0];

    // flag after a load matches the divisor now held in the shift and increment registers
    a_divide_by_zero_capture: assert property (
        @(posedge clock) disable iff (!arst_n)
        ctrl.load |=> (divide_by_zero == ((divisor_shift == '0) && (increment == '0)))
    );

endmodule

/* verilog/div_ctrl_pkg.sv */
// control types passed from the divider FSM to its datapath units
package div_ctrl_pkg;

    // step counter width, enough to hold the first step count
    localparam int step_width = 6;

    typedef logic [step_width-1:0] step_t;

    // one load cycle, then 33 division steps counting 32 down to 0
    localparam step_t steps_initial = 6'd32;

    // load waits for operands, calc runs the steps, done holds the result
    typedef enum logic [1:0] {
        state_load = 2'b00,
        state_calc = 2'b01,
        state_done = 2'b10
    } div_state_e;

    typedef struct packed {
        // input handshake fires this cycle
        logic load;
        // one division step runs this cycle
        logic calculating;
    } div_ctrl_t;

endpackage

/* verilog/div_data_pkg.sv */
// word widths and request/result types shared by the divider datapath and its testbench
package div_data_pkg;

    // external word width seen at both handshakes
    localparam int word_width = 32;

    // internal width is one bit wider
    // so the most negative word can still be negated
    localparam int long_width = word_width + 1;

    // dividend, divisor, quotient or remainder at the ports
    typedef logic [word_width-1:0] word_t;

    // internal sign-extended value used by the long division
    typedef logic [long_width-1:0] long_t;

    // operands presented with in_valid
    // dividend sits in the upper half of the struct
    typedef struct packed {
        word_t dividend;
        word_t divisor;
    } div_request_t;

    // results presented with out_valid
    // quotient rounds toward zero, remainder follows the dividend sign
    typedef struct packed {
        word_t quotient;
        word_t remainder;
        // set when the captured divisor was zero
        logic  divide_by_zero;
    } div_result_t;

endpackage
